/* all.f */
+incdir+tb
design/keccak_pkg.sv
design/keccak_fsm.sv
design/round_counter.sv
design/theta_step.sv
design/rho_pi_step.sv
design/chi_iota_step.sv
design/keccak_f1600.sv
tb/keccak_f1600_assertions.sv
tb/keccak_f1600_tb.sv

/* design/chi_iota_step.sv */
`default_nettype none
`timescale 1ns/1ns

module chi_iota_step (
    input  logic                  clk,
    input  logic                  load,
    input  logic                  chi_en,
    input  logic                  iota_en,
    input  keccak_pkg::state_vec_t load_state,
    input  keccak_pkg::state_vec_t pi_lanes,
    input  keccak_pkg::round_t     round,
    output keccak_pkg::state_vec_t state_lanes
);
    import keccak_pkg::*;

    state_vec_t chi_next;
    state_vec_t chi_lanes;

    // row-wise nonlinear step
    always_comb begin
        for (int y = 0; y < GRID; y++) begin
            for (int x = 0; x < GRID; x++) begin
                chi_next[LANE_W*(x+GRID*y) +: LANE_W] =
                    pi_lanes[LANE_W*(x+GRID*y) +: LANE_W]
                    ^ (~pi_lanes[LANE_W*(((x+1) % GRID)+GRID*y) +: LANE_W]
                       & pi_lanes[LANE_W*(((x+2) % GRID)+GRID*y) +: LANE_W]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (chi_en) begin
            chi_lanes <= chi_next;
        end
    end

    ////////////////////
    // iota / state register
    ////////////////////
    always_ff @(posedge clk) begin
        if (load) begin
            state_lanes <= load_state;
        end else if (iota_en) begin
            // constant only touches lane (0,0)
            state_lanes <= {chi_lanes[STATE_W-1:LANE_W],
                            chi_lanes[LANE_W-1:0] ^ ROUND_CONST[round]};
        end
    end

endmodule

`default_nettype wire

/* design/keccak_f1600.sv */
`default_nettype none
`timescale 1ns/1ns

module keccak_f1600 (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  go,
    input  logic                  kill,
    input  keccak_pkg::state_vec_t state,
    output logic                  done,
    output keccak_pkg::state_vec_t state_out
);
    import keccak_pkg::*;

    logic       load;
    logic       parity_en;
    logic       mix_en;
    logic       apply_en;
    logic       rho_pi_en;
    logic       chi_en;
    logic       iota_en;
    logic       round_clear;
    logic       finish;
    logic       last_round;
    round_t     round;
    state_vec_t load_state;
    state_vec_t state_lanes;
    state_vec_t theta_lanes;
    state_vec_t pi_lanes;
    state_vec_t packed_out;

    function automatic lane_t byte_swap(input lane_t v);
        lane_t r;
        for (int b = 0; b < LANE_W/8; b++) begin
            r[8*b +: 8] = v[LANE_W-8-8*b +: 8];
        end
        return r;
    endfunction

    ////////////////////
    // lane packing
    ////////////////////
    // external lane k sits at the top, bytes reversed
    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            load_state[LANE_W*k +: LANE_W] = byte_swap(state[STATE_W-1-LANE_W*k -: LANE_W]);
            packed_out[STATE_W-1-LANE_W*k -: LANE_W] = byte_swap(state_lanes[LANE_W*k +: LANE_W]);
        end
    end

    always_ff @(posedge clk) begin
        if (finish) begin
            state_out <= packed_out;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= finish;
        end
    end

    ////////////////////
    // instances
    ////////////////////
    keccak_fsm u_fsm (
        .clk         (clk),
        .reset       (reset),
        .go          (go),
        .kill        (kill),
        .last_round  (last_round),
        .load        (load),
        .parity_en   (parity_en),
        .mix_en      (mix_en),
        .apply_en    (apply_en),
        .rho_pi_en   (rho_pi_en),
        .chi_en      (chi_en),
        .iota_en     (iota_en),
        .round_clear (round_clear),
        .finish      (finish)
    );

    round_counter u_round (
        .clk         (clk),
        .reset       (reset),
        .round_clear (round_clear),
        .iota_en     (iota_en),
        .round       (round),
        .last_round  (last_round)
    );

    theta_step u_theta (
        .clk         (clk),
        .parity_en   (parity_en),
        .mix_en      (mix_en),
        .apply_en    (apply_en),
        .state_lanes (state_lanes),
        .theta_lanes (theta_lanes)
    );

    rho_pi_step u_rho_pi (
        .clk         (clk),
        .rho_pi_en   (rho_pi_en),
        .theta_lanes (theta_lanes),
        .pi_lanes    (pi_lanes)
    );

    chi_iota_step u_chi_iota (
        .clk         (clk),
        .load        (load),
        .chi_en      (chi_en),
        .iota_en     (iota_en),
        .load_state  (load_state),
        .pi_lanes    (pi_lanes),
        .round       (round),
        .state_lanes (state_lanes)
    );

endmodule

`default_nettype wire

/* design/keccak_fsm.sv */
`default_nettype none
`timescale 1ns/1ns

module keccak_fsm (
    input  logic clk,
    input  logic reset,
    input  logic go,
    input  logic kill,
    input  logic last_round,
    output logic load,
    output logic parity_en,
    output logic mix_en,
    output logic apply_en,
    output logic rho_pi_en,
    output logic chi_en,
    output logic iota_en,
    output logic round_clear,
    output logic finish
);
    import keccak_pkg::*;

    keccak_phase_t phase;
    keccak_phase_t phase_next;
    logic          in_step;

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= PH_IDLE;
        end else begin
            phase <= phase_next;
        end
    end

    always_comb begin
        phase_next = phase;
        case (phase)
            PH_IDLE:   if (go) phase_next = PH_PARITY;
            PH_PARITY: phase_next = PH_MIX;
            PH_MIX:    phase_next = PH_APPLY;
            PH_APPLY:  phase_next = PH_RHO_PI;
            PH_RHO_PI: phase_next = PH_CHI;
            PH_CHI:    phase_next = PH_IOTA;
            PH_IOTA:   phase_next = last_round ? PH_FINISH : PH_PARITY;
            PH_FINISH: phase_next = PH_IDLE;
            PH_ABORT:  if (!kill) phase_next = PH_IDLE;
            default:   phase_next = PH_IDLE;
        endcase
        // kill wins over any step transition
        if (in_step && kill) begin
            phase_next = PH_ABORT;
        end
    end

    // step strobes
    assign parity_en = (phase == PH_PARITY);
    assign mix_en    = (phase == PH_MIX);
    assign apply_en  = (phase == PH_APPLY);
    assign rho_pi_en = (phase == PH_RHO_PI);
    assign chi_en    = (phase == PH_CHI);
    assign iota_en   = (phase == PH_IOTA);

    assign in_step = parity_en | mix_en | apply_en | rho_pi_en | chi_en | iota_en;

    assign load        = (phase == PH_IDLE) && go;
    assign finish      = (phase == PH_FINISH);
    assign round_clear = (phase == PH_IDLE) || (phase == PH_FINISH) || (phase == PH_ABORT);

endmodule

`default_nettype wire

/* design/keccak_pkg.sv */
`default_nettype none

package keccak_pkg;

    ////////////////////
    // widths and types
    ////////////////////
    localparam int LANE_W     = 64;
    localparam int GRID       = 5;
    localparam int NUM_LANES  = GRID * GRID;
    localparam int STATE_W    = LANE_W * NUM_LANES;
    localparam int NUM_ROUNDS = 24;

    typedef logic [LANE_W-1:0]  lane_t;
    // lane (x,y) at bits 64*(x+5y) upward
    typedef logic [STATE_W-1:0] state_vec_t;
    typedef logic [4:0]         round_t;

    ////////////////////
    // iota constants
    ////////////////////
    localparam lane_t ROUND_CONST [NUM_ROUNDS] = '{
        64'h0000_0000_0000_0001, 64'h0000_0000_0000_8082,
        64'h8000_0000_0000_808a, 64'h8000_0000_8000_8000,
        64'h0000_0000_0000_808b, 64'h0000_0000_8000_0001,
        64'h8000_0000_8000_8081, 64'h8000_0000_0000_8009,
        64'h0000_0000_0000_008a, 64'h0000_0000_0000_0088,
        64'h0000_0000_8000_8009, 64'h0000_0000_8000_000a,
        64'h0000_0000_8000_808b, 64'h8000_0000_0000_008b,
        64'h8000_0000_0000_8089, 64'h8000_0000_0000_8003,
        64'h8000_0000_0000_8002, 64'h8000_0000_0000_0080,
        64'h0000_0000_0000_800a, 64'h8000_0000_8000_000a,
        64'h8000_0000_8000_8081, 64'h8000_0000_0000_8080,
        64'h0000_0000_8000_0001, 64'h8000_0000_8000_8008
    };

    // rotate-left amounts, indexed by x+5y
    localparam logic [5:0] RHO_OFFSET [NUM_LANES] = '{
         0,  1, 62, 28, 27,
        36, 44,  6, 55, 20,
         3, 10, 43, 25, 39,
        41, 45, 15, 21,  8,
        18,  2, 61, 56, 14
    };

    ////////////////////
    // control phases
    ////////////////////
    typedef enum logic [3:0] {
        PH_IDLE,
        PH_PARITY,
        PH_MIX,
        PH_APPLY,
        PH_RHO_PI,
        PH_CHI,
        PH_IOTA,
        PH_FINISH,
        PH_ABORT
    } keccak_phase_t;

endpackage

`default_nettype wire

/* design/rho_pi_step.sv */
`default_nettype none
`timescale 1ns/1ns

module rho_pi_step (
    input  logic                  clk,
    input  logic                  rho_pi_en,
    input  keccak_pkg::state_vec_t theta_lanes,
    output keccak_pkg::state_vec_t pi_lanes
);
    import keccak_pkg::*;

    state_vec_t moved;

    function automatic lane_t rotl(input lane_t v, input logic [5:0] n);
        // n of zero shifts the right half out entirely
        return (v << n) | (v >> (LANE_W - n));
    endfunction

    // (x,y) goes to (y, 2x+3y mod 5)
    always_comb begin
        for (int y = 0; y < GRID; y++) begin
            for (int x = 0; x < GRID; x++) begin
                moved[LANE_W*(y + GRID*((2*x + 3*y) % GRID)) +: LANE_W] =
                    rotl(theta_lanes[LANE_W*(x+GRID*y) +: LANE_W], RHO_OFFSET[x+GRID*y]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rho_pi_en) begin
            pi_lanes <= moved;
        end
    end

endmodule

`default_nettype wire

/* design/round_counter.sv */
`default_nettype none
`timescale 1ns/1ns

module round_counter (
    input  logic              clk,
    input  logic              reset,
    input  logic              round_clear,
    input  logic              iota_en,
    output keccak_pkg::round_t round,
    output logic              last_round
);
    import keccak_pkg::*;

    always_ff @(posedge clk) begin
        if (reset) begin
            round <= '0;
        end else if (round_clear) begin
            round <= '0;
        end else if (iota_en) begin
            round <= round + round_t'(1);
        end
    end

    assign last_round = (round == round_t'(NUM_ROUNDS - 1));

endmodule

`default_nettype wire

/* design/theta_step.sv */
`default_nettype none
`timescale 1ns/1ns

module theta_step (
    input  logic                  clk,
    input  logic                  parity_en,
    input  logic                  mix_en,
    input  logic                  apply_en,
    input  keccak_pkg::state_vec_t state_lanes,
    output keccak_pkg::state_vec_t theta_lanes
);
    import keccak_pkg::*;

    lane_t col_par [GRID];
    lane_t parity  [GRID];
    lane_t mix     [GRID];

    // column parity over the five rows
    always_comb begin
        for (int x = 0; x < GRID; x++) begin
            col_par[x] = '0;
            for (int y = 0; y < GRID; y++) begin
                col_par[x] = col_par[x] ^ state_lanes[LANE_W*(x+GRID*y) +: LANE_W];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (parity_en) begin
            for (int x = 0; x < GRID; x++) begin
                parity[x] <= col_par[x];
            end
        end
    end

    // neighbour columns, right one rotated by one
    always_ff @(posedge clk) begin
        if (mix_en) begin
            for (int x = 0; x < GRID; x++) begin
                mix[x] <= parity[(x+GRID-1) % GRID]
                          ^ {parity[(x+1) % GRID][LANE_W-2:0],
                             parity[(x+1) % GRID][LANE_W-1]};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (apply_en) begin
            for (int y = 0; y < GRID; y++) begin
                for (int x = 0; x < GRID; x++) begin
                    theta_lanes[LANE_W*(x+GRID*y) +: LANE_W] <=
                        state_lanes[LANE_W*(x+GRID*y) +: LANE_W] ^ mix[x];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb/keccak_f1600_assertions.sv */
`default_nettype none
`timescale 1ns/1ns

module keccak_f1600_assertions (
    input logic                      clk,
    input logic                      reset,
    input logic                      kill,
    input keccak_pkg::keccak_phase_t phase,
    input logic                      parity_en,
    input logic                      mix_en,
    input logic                      apply_en,
    input logic                      rho_pi_en,
    input logic                      chi_en,
    input logic                      iota_en,
    input logic                      finish
);
    import keccak_pkg::*;

    int   failures = 0;
    logic in_step;

    assign in_step = phase inside {PH_PARITY, PH_MIX, PH_APPLY, PH_RHO_PI, PH_CHI, PH_IOTA};

    assert property (@(posedge clk) disable iff (reset) in_step && kill |=> phase == PH_ABORT)
    else begin
        failures++;
        $error("kill in a step phase did not lead to abort");
    end

    assert property (@(posedge clk) disable iff (reset) finish |=> phase == PH_IDLE)
    else begin
        failures++;
        $error("finish was not followed by idle");
    end

    // one strobe per step phase
    assert property (@(posedge clk) disable iff (reset)
        in_step |-> $onehot({parity_en, mix_en, apply_en, rho_pi_en, chi_en, iota_en}))
    else begin
        failures++;
        $error("step phase without exactly one strobe");
    end

endmodule

bind keccak_fsm keccak_f1600_assertions u_assertions (.*);

`default_nettype wire

/* tb/keccak_ref.svh */
`ifndef KECCAK_REF_SVH
`define KECCAK_REF_SVH

// rotate-left amounts for lane x+5y
localparam int RHO [25] = '{
     0,  1, 62, 28, 27,
    36, 44,  6, 55, 20,
     3, 10, 43, 25, 39,
    41, 45, 15, 21,  8,
    18,  2, 61, 56, 14
};

function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

function automatic logic [63:0] rotate_left(input logic [63:0] v, input int n);
    return (n == 0) ? v : ((v << n) | (v >> (64 - n)));
endfunction

function automatic logic [63:0] reverse_bytes(input logic [63:0] v);
    logic [63:0] w;
    for (int i = 0; i < 8; i++)
        w[8*i +: 8] = v[56-8*i +: 8];
    return w;
endfunction

// external lane k is bits 1599-64k downward, bytes reversed
function automatic logic [1599:0] keccak_f1600_model(input logic [1599:0] ext);
    logic [63:0]   a [25];
    logic [63:0]   b [25];
    logic [63:0]   c [5];
    logic [63:0]   rc;
    logic [7:0]    lfsr;
    logic [1599:0] res;
    for (int k = 0; k < 25; k++)
        a[k] = reverse_bytes(ext[1599-64*k -: 64]);
    lfsr = 8'h01;
    for (int r = 0; r < 24; r++) begin
        for (int i = 0; i < 5; i++)
            c[i] = a[i] ^ a[i+5] ^ a[i+10] ^ a[i+15] ^ a[i+20];
        for (int k = 0; k < 25; k++)
            a[k] = a[k] ^ c[(k+4)%5] ^ rotate_left(c[(k+1)%5], 1);
        for (int k = 0; k < 25; k++)
            b[k/5 + 5*((2*(k%5) + 3*(k/5)) % 5)] = rotate_left(a[k], RHO[k]);
        for (int k = 0; k < 25; k++)
            a[k] = b[k] ^ (~b[5*(k/5) + (k+1)%5] & b[5*(k/5) + (k+2)%5]);
        // bits 2^j-1 of the round constant, seven rc LFSR steps per round
        rc = '0;
        for (int j = 0; j < 7; j++) begin
            rc[(1 << j) - 1] = lfsr[0];
            lfsr = lfsr[7] ? ((lfsr << 1) ^ 8'h71) : (lfsr << 1);
        end
        a[0] = a[0] ^ rc;
    end
    for (int k = 0; k < 25; k++)
        res[1599-64*k -: 64] = reverse_bytes(a[k]);
    return res;
endfunction

task automatic check_value(input string name, input logic [1599:0] actual,
                           input logic [1599:0] expected);
    if (actual !== expected) begin
        mismatches++;
        $display("mismatch at %0t ns: %s is %0h, expected %0h",
                 $time, name, actual, expected);
    end
endtask

`endif

/* tb/keccak_f1600_tb.sv */
`default_nettype none
`timescale 1ns/1ns

module keccak_f1600_tb;

    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 3;
    localparam int DONE_LATENCY   = 145;
    localparam int RUN_WAIT       = 2 * DONE_LATENCY;
    localparam int KILL_WINDOW    = 200;
    // nine full runs and the killed one need about 1600 cycles
    localparam int TIMEOUT_CYCLES = 2500;

    logic          clk = 1'b0;
    logic          reset;
    logic          go;
    logic          kill;
    logic [1599:0] state;
    logic          done;
    logic [1599:0] state_out;

    int            cycle_count = 0;
    int            done_count = 0;
    int            go_cycle = 0;
    int            mismatches = 0;
    int            other_errors = 0;
    int            total_errors;
    logic          prev_done = 1'b0;
    logic [31:0]   rand_state = 32'h67fb_a75d;
    logic [1599:0] stim;
    logic [1599:0] expected_q [$];

    `include "keccak_ref.svh"

    keccak_f1600 DUT (
        .clk       (clk),
        .reset     (reset),
        .go        (go),
        .kill      (kill),
        .state     (state),
        .done      (done),
        .state_out (state_out)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    ////////////////////
    // checker
    ////////////////////
    // outputs sampled on the falling edge
    always @(negedge clk) begin
        if (done && prev_done) begin
            other_errors++;
            $display("done stayed high for more than one cycle at %0t ns", $time);
        end else if (done) begin
            done_count++;
            if (expected_q.size() == 0) begin
                other_errors++;
                $display("done at %0t ns without a pending run", $time);
            end else begin
                check_value("state_out", state_out, expected_q.pop_front());
                check_value("done latency", cycle_count - go_cycle, DONE_LATENCY);
            end
        end
        prev_done = done;
    end

    task automatic fill_random(output logic [1599:0] s);
        for (int i = 0; i < 50; i++) begin
            rand_state = lcg_next(rand_state);
            s[32*i +: 32] = rand_state;
        end
    endtask

    // stray go and kill offsets in cycles after the go edge
    // zero offset means none
    task automatic run_permutation(input logic [1599:0] s, input int stray_go_at,
                                   input int kill_at);
        int start_count;
        int limit;
        start_count = done_count;
        limit = (kill_at == 0) ? RUN_WAIT : kill_at + 3 + KILL_WINDOW;
        @(posedge clk);
        #1;
        state = s;
        go = 1'b1;
        @(posedge clk);
        #1;
        go = 1'b0;
        // input only matters at the go edge
        state = ~s;
        go_cycle = cycle_count;
        if (kill_at == 0) begin
            expected_q.push_back(keccak_f1600_model(s));
        end
        for (int n = 1; n <= limit && done_count == start_count; n++) begin
            go = (n == stray_go_at);
            kill = (kill_at != 0) && (n >= kill_at) && (n < kill_at + 3);
            @(posedge clk);
            #1;
        end
        go = 1'b0;
        kill = 1'b0;
        if (kill_at != 0) begin
            check_value("done count after kill", done_count - start_count, '0);
        end else if (done_count == start_count) begin
            other_errors++;
            $display("no done within %0d cycles of go at %0t ns", limit, $time);
        end
    endtask

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end

    ////////////////////
    // stimulus
    ////////////////////
    initial begin
        reset = 1'b1;
        go = 1'b0;
        kill = 1'b0;
        state = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_value("done after reset", done, '0);
        run_permutation('0, 0, 0);
        repeat (6) begin
            fill_random(stim);
            run_permutation(stim, 0, 0);
        end
        // second go in round 7 must be ignored
        fill_random(stim);
        run_permutation(stim, 40, 0);
        // kill in round 10 and a clean run after it
        fill_random(stim);
        run_permutation(stim, 0, 60);
        fill_random(stim);
        run_permutation(stim, 0, 0);
        repeat (4) @(posedge clk);
        total_errors = mismatches + other_errors + DUT.u_fsm.u_assertions.failures;
        $display("errors: %0d mismatches, %0d other, %0d assertion failures",
                 mismatches, other_errors, DUT.u_fsm.u_assertions.failures);
        if (total_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
